// ==== sim.f ====
+incdir+hdl
hdl/axi_periph_pkg.sv
hdl/axi_chan_hold.sv
hdl/axi_write_path.sv
hdl/axi_read_path.sv
hdl/reg_bank.sv
hdl/axi_dummy_periph.sv
test/tb_axi_dummy_periph.sv

// ==== Makefile ====
TOP = tb_axi_dummy_periph

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f sim.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// ==== test/tb_axi_dummy_periph.sv ====
// Directed testbench for the AXI4-Lite dummy peripheral
// Model register array, write and read bus tasks, typed compare tasks
// and a cycle-count timeout

`timescale 1ns/10ps

`include "axi_periph_config.svh"

module tb_axi_dummy_periph;

  import axi_periph_pkg::*;

  // Worst transaction with delays and back-pressure stays well under this
  localparam int MAX_TXN_CYCLES = 24;
  localparam int TXN_COUNT      = 256;
  localparam int TIMEOUT_CYCLES = TXN_COUNT * MAX_TXN_CYCLES + 100;

  logic        s_axi_aclk;
  logic        s_axi_aresetn;
  axi_addr_t   s_axi_awaddr;
  logic [2:0]  s_axi_awprot;
  logic        s_axi_awvalid;
  logic        s_axi_awready;
  axi_data_t   s_axi_wdata;
  axi_strb_t   s_axi_wstrb;
  logic        s_axi_wvalid;
  logic        s_axi_wready;
  axi_resp_t   s_axi_bresp;
  logic        s_axi_bvalid;
  logic        s_axi_bready;
  axi_addr_t   s_axi_araddr;
  logic [2:0]  s_axi_arprot;
  logic        s_axi_arvalid;
  logic        s_axi_arready;
  axi_data_t   s_axi_rdata;
  axi_resp_t   s_axi_rresp;
  logic        s_axi_rvalid;
  logic        s_axi_rready;
  reg_strobe_t reg_strobes;

  // Expected register contents
  axi_data_t model_regs [`REG_COUNT];

  int    seed;
  int    errors;
  int    tests_run;
  int    tests_failed;
  int    test_start_errors;
  int    cycle_count = 0;
  string test_name;

  axi_dummy_periph i_dut (.*);

  initial begin
    s_axi_aclk = 1'b0;
    forever #2 s_axi_aclk = ~s_axi_aclk;
  end

  // Run limit in case a handshake never completes
  always @(posedge s_axi_aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: no handshake after %0d cycles in %s", cycle_count, test_name);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR in %s: %s", test_name, msg);
  endtask

  task automatic check_data(input string what, input axi_data_t exp, input axi_data_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s, %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s, %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_strobes(input string what, input reg_strobe_t exp,
                               input reg_strobe_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s, %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // Byte addresses map to registers with bits 1:0 ignored
  function automatic reg_idx_t reg_of(input axi_addr_t addr);
    return reg_idx_t'(addr >> 2);
  endfunction

  // Byte-lane update rule
  function automatic axi_data_t merge_bytes(input axi_data_t old_w, input axi_data_t new_w,
                                            input axi_strb_t strb);
    axi_data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_start_errors) begin
      $display("PASS %s", test_name);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", test_name, errors - test_start_errors);
    end
  endtask

  // Holds reset for 3 cycles and expects the readies one cycle after release
  task automatic apply_reset();
    s_axi_aresetn <= 1'b0;
    for (int i = 0; i < 3; i++) begin
      @(posedge s_axi_aclk);
      if (i > 0) begin
        if (s_axi_awready || s_axi_wready || s_axi_arready || s_axi_bvalid || s_axi_rvalid)
          report_error("ready or valid high during reset");
        check_strobes("strobes in reset", '0, reg_strobes);
      end
    end
    s_axi_aresetn <= 1'b1;
    @(posedge s_axi_aclk);
    if (s_axi_awready || s_axi_wready || s_axi_arready)
      report_error("ready high in the cycle reset ends");
    @(posedge s_axi_aclk);
    if (!(s_axi_awready && s_axi_wready && s_axi_arready))
      report_error("ready not high one cycle after reset");
    for (int i = 0; i < `REG_COUNT; i++) begin
      model_regs[i] = 32'h100 + 4 * i;
    end
  endtask

  // One write with AW and W offered after their own delays and BREADY held off b_hold cycles
  task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                           input int aw_dly, input int w_dly, input int b_hold);
    int          cyc;
    int          last_hs;
    int          bv_cycles;
    bit          aw_done;
    bit          w_done;
    bit          b_done;
    reg_strobe_t exp_strobes;
    cyc = 0;
    last_hs = -10;
    bv_cycles = 0;
    aw_done = 1'b0;
    w_done = 1'b0;
    b_done = 1'b0;
    exp_strobes = '0;
    if (strb != '0) begin
      exp_strobes[reg_of(addr)] = 1'b1;
    end
    s_axi_bready <= (b_hold == 0);
    while (!b_done) begin
      @(posedge s_axi_aclk);
      if ((aw_done && s_axi_awready) || (w_done && s_axi_wready))
        report_error("AWREADY or WREADY high while a beat is held");
      if (s_axi_bvalid) begin
        if (bv_cycles == 0) begin
          if (!(aw_done && w_done) || cyc != last_hs + 1)
            report_error("BVALID not one cycle after both write beats");
          check_strobes("write pulse", exp_strobes, reg_strobes);
        end else begin
          check_strobes("after write pulse", '0, reg_strobes);
        end
        check_resp("BRESP", RESP_OKAY, s_axi_bresp);
        bv_cycles++;
        if (s_axi_bready) begin
          b_done = 1'b1;
        end else begin
          s_axi_bready <= (bv_cycles >= b_hold);
        end
      end else begin
        if (bv_cycles > 0)
          report_error("BVALID dropped before BREADY");
        check_strobes("before response", '0, reg_strobes);
      end
      if (s_axi_awvalid && s_axi_awready) begin
        aw_done = 1'b1;
        last_hs = cyc;
        s_axi_awvalid <= 1'b0;
      end
      if (s_axi_wvalid && s_axi_wready) begin
        w_done = 1'b1;
        last_hs = cyc;
        s_axi_wvalid <= 1'b0;
      end
      if (!aw_done && cyc == aw_dly) begin
        s_axi_awvalid <= 1'b1;
        s_axi_awaddr <= addr;
      end
      if (!w_done && cyc == w_dly) begin
        s_axi_wvalid <= 1'b1;
        s_axi_wdata <= data;
        s_axi_wstrb <= strb;
      end
      cyc++;
    end
    s_axi_bready <= 1'b0;
    @(posedge s_axi_aclk);
    if (s_axi_bvalid)
      report_error("second write response after the B handshake");
    if (!(s_axi_awready && s_axi_wready))
      report_error("AWREADY or WREADY not back one cycle after the B handshake");
    check_strobes("after response", '0, reg_strobes);
    model_regs[reg_of(addr)] = merge_bytes(model_regs[reg_of(addr)], data, strb);
  endtask

  // One read with RREADY held off r_hold cycles after RVALID
  task automatic axi_read(input axi_addr_t addr, input int r_hold, output axi_data_t data);
    int cyc;
    int hs_cyc;
    int rv_cycles;
    bit ar_done;
    bit r_done;
    cyc = 0;
    hs_cyc = -10;
    rv_cycles = 0;
    ar_done = 1'b0;
    r_done = 1'b0;
    data = '0;
    s_axi_arvalid <= 1'b1;
    s_axi_araddr <= addr;
    s_axi_rready <= (r_hold == 0);
    while (!r_done) begin
      @(posedge s_axi_aclk);
      if (s_axi_rvalid) begin
        if (rv_cycles == 0) begin
          if (!ar_done || cyc != hs_cyc + 1)
            report_error("RVALID not one cycle after the AR handshake");
          data = s_axi_rdata;
        end else begin
          check_data("RDATA under back-pressure", data, s_axi_rdata);
        end
        check_resp("RRESP", RESP_OKAY, s_axi_rresp);
        if (s_axi_arready)
          report_error("ARREADY high while RVALID is pending");
        rv_cycles++;
        if (s_axi_rready) begin
          r_done = 1'b1;
        end else begin
          s_axi_rready <= (rv_cycles >= r_hold);
        end
      end else if (rv_cycles > 0) begin
        report_error("RVALID dropped before RREADY");
      end
      if (s_axi_arvalid && s_axi_arready) begin
        ar_done = 1'b1;
        hs_cyc = cyc;
        s_axi_arvalid <= 1'b0;
      end
      cyc++;
    end
    s_axi_rready <= 1'b0;
    @(posedge s_axi_aclk);
    if (s_axi_rvalid)
      report_error("second read response after the R handshake");
    if (!s_axi_arready)
      report_error("ARREADY not back one cycle after the R handshake");
  endtask

  task automatic read_and_compare(input axi_addr_t addr, input int r_hold);
    axi_data_t data;
    axi_read(addr, r_hold, data);
    check_data($sformatf("read of 0x%02h", addr), model_regs[reg_of(addr)], data);
  endtask

  task automatic read_sweep();
    for (int i = 0; i < `REG_COUNT; i++) begin
      read_and_compare(axi_addr_t'(4 * i), 0);
    end
  endtask

  task automatic test_reset_contents();
    start_test("reset contents");
    apply_reset();
    read_sweep();
    end_test();
  endtask

  task automatic test_full_writes();
    axi_addr_t addr;
    start_test("full-word writes");
    for (int n = 0; n < 16; n++) begin
      // Bits 1:0 vary since the target ignores them
      addr = {reg_idx_t'($random(seed)), 2'($random(seed))};
      axi_write(addr, axi_data_t'($random(seed)), 4'hF, 0, 0, 0);
      read_and_compare(addr, 0);
    end
    end_test();
  endtask

  task automatic test_partial_writes();
    axi_addr_t addr;
    start_test("partial writes");
    for (int n = 0; n < 16; n++) begin
      addr = {reg_idx_t'($random(seed)), 2'b00};
      axi_write(addr, axi_data_t'($random(seed)), axi_strb_t'($random(seed)), 0, 0, 0);
      read_and_compare(addr, 0);
    end
    // No lanes enabled so neither contents nor strobes change
    axi_write(8'h40, 32'hDEAD_BEEF, 4'h0, 0, 0, 0);
    read_and_compare(8'h40, 0);
    end_test();
  endtask

  task automatic test_ordering();
    axi_addr_t addr;
    int        dly;
    start_test("channel ordering");
    for (int n = 0; n < 4; n++) begin
      for (int mode = 0; mode < 3; mode++) begin
        dly = 1 + int'($unsigned($random(seed)) % 5);
        addr = {reg_idx_t'($random(seed)), 2'b00};
        // Mode 0 sends the address first, mode 1 the data first and mode 2 both together
        axi_write(addr, axi_data_t'($random(seed)), 4'hF,
                  (mode == 1) ? dly : 0, (mode == 0) ? dly : 0, 0);
        read_and_compare(addr, 0);
      end
    end
    end_test();
  endtask

  task automatic test_back_pressure();
    axi_addr_t addr;
    start_test("back-pressure");
    for (int n = 0; n < 8; n++) begin
      addr = {reg_idx_t'($random(seed)), 2'b00};
      axi_write(addr, axi_data_t'($random(seed)), 4'hF, 0, 0,
                1 + int'($unsigned($random(seed)) % 8));
      read_and_compare(addr, 1 + int'($unsigned($random(seed)) % 8));
    end
    end_test();
  endtask

  task automatic test_re_reset();
    start_test("re-reset");
    apply_reset();
    read_sweep();
    end_test();
  endtask

  initial begin
    seed = 14;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_start_errors = 0;
    test_name = "startup";
    s_axi_aresetn <= 1'b0;
    s_axi_awaddr <= '0;
    s_axi_awprot <= '0;
    s_axi_awvalid <= 1'b0;
    s_axi_wdata <= '0;
    s_axi_wstrb <= '0;
    s_axi_wvalid <= 1'b0;
    s_axi_bready <= 1'b0;
    s_axi_araddr <= '0;
    s_axi_arprot <= '0;
    s_axi_arvalid <= 1'b0;
    s_axi_rready <= 1'b0;
    test_reset_contents();
    test_full_writes();
    test_partial_writes();
    test_ordering();
    test_back_pressure();
    test_re_reset();
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== hdl/axi_dummy_periph.sv ====
// Top level of the AXI4-Lite dummy peripheral
// Connects the slave port to the write path, read path and register bank

`timescale 1ns/10ps

module axi_dummy_periph (
  input  logic                        s_axi_aclk,
  input  logic                        s_axi_aresetn,
  // Write address channel
  input  axi_periph_pkg::axi_addr_t   s_axi_awaddr,
  input  logic [2:0]                  s_axi_awprot,
  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,
  // Write data channel
  input  axi_periph_pkg::axi_data_t   s_axi_wdata,
  input  axi_periph_pkg::axi_strb_t   s_axi_wstrb,
  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,
  // Write response channel
  output axi_periph_pkg::axi_resp_t   s_axi_bresp,
  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,
  // Read address channel
  input  axi_periph_pkg::axi_addr_t   s_axi_araddr,
  input  logic [2:0]                  s_axi_arprot,
  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,
  // Read data channel
  output axi_periph_pkg::axi_data_t   s_axi_rdata,
  output axi_periph_pkg::axi_resp_t   s_axi_rresp,
  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready,
  // Update pulses toward host-side logic
  output axi_periph_pkg::reg_strobe_t reg_strobes
);

  import axi_periph_pkg::*;

  // Write port into the register bank
  logic      wr_en;
  reg_idx_t  wr_idx;
  axi_data_t wr_data;
  axi_strb_t wr_strb;

  // Read port
  reg_idx_t  rd_idx;
  axi_data_t rd_data;

  // AWPROT and ARPROT carry no meaning for this target

  axi_write_path i_write_path (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .awaddr        (s_axi_awaddr),
    .awvalid       (s_axi_awvalid),
    .awready       (s_axi_awready),
    .wdata         (s_axi_wdata),
    .wstrb         (s_axi_wstrb),
    .wvalid        (s_axi_wvalid),
    .wready        (s_axi_wready),
    .bresp         (s_axi_bresp),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb)
  );

  axi_read_path i_read_path (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .araddr        (s_axi_araddr),
    .arvalid       (s_axi_arvalid),
    .arready       (s_axi_arready),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data),
    .rdata         (s_axi_rdata),
    .rresp         (s_axi_rresp),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready)
  );

  reg_bank i_reg_bank (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data),
    .reg_strobes   (reg_strobes)
  );

endmodule

// ==== hdl/reg_bank.sv ====
// Host-accessible register file of the dummy peripheral
// 64 words with address-based reset pattern, byte-strobed write,
// combinational read port and per-register write pulses

`timescale 1ns/10ps

`include "axi_periph_config.svh"

module reg_bank (
  input  logic                        s_axi_aclk,
  input  logic                        s_axi_aresetn,
  input  logic                        wr_en,
  input  axi_periph_pkg::reg_idx_t    wr_idx,
  input  axi_periph_pkg::axi_data_t   wr_data,
  input  axi_periph_pkg::axi_strb_t   wr_strb,
  input  axi_periph_pkg::reg_idx_t    rd_idx,
  output axi_periph_pkg::axi_data_t   rd_data,
  output axi_periph_pkg::reg_strobe_t reg_strobes
);

  import axi_periph_pkg::*;

  // Register storage
  axi_data_t regs [`REG_COUNT];

  // Register contents
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      // Each word resets to base plus its byte address
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= axi_data_t'(`REG_INIT_BASE + (i << `REG_ADDR_LSB));
      end
    end else if (wr_en) begin
      // Only enabled byte lanes change
      for (int b = 0; b < `AXI_DATA_W/8; b++) begin
        if (wr_strb[b]) begin
          regs[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // One-cycle update pulse, lines up with BVALID rising
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      reg_strobes <= '0;
    end else begin
      reg_strobes <= '0;
      // No pulse for a write with every strobe off
      if (wr_en && (|wr_strb)) begin
        reg_strobes[wr_idx] <= 1'b1;
      end
    end
  end

  // Read sees the value before any same-cycle write
  assign rd_data = regs[rd_idx];

endmodule

// ==== hdl/axi_read_path.sv ====
// AXI4-Lite read side of the dummy peripheral
// Accepts one read address at a time, captures the register word
// and holds RVALID and RDATA until the host takes them

`timescale 1ns/10ps

`include "axi_periph_config.svh"

module axi_read_path (
  input  logic                      s_axi_aclk,
  input  logic                      s_axi_aresetn,
  input  axi_periph_pkg::axi_addr_t araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output axi_periph_pkg::reg_idx_t  rd_idx,
  input  axi_periph_pkg::axi_data_t rd_data,
  output axi_periph_pkg::axi_data_t rdata,
  output axi_periph_pkg::axi_resp_t rresp,
  output logic                      rvalid,
  input  logic                      rready
);

  import axi_periph_pkg::*;

  // AR handshake
  logic ar_hs;

  assign ar_hs = arvalid && arready;

  // Register select straight from the bus address
  assign rd_idx = araddr[`REG_ADDR_LSB +: `REG_IDX_W];

  // ARREADY drops on acceptance and returns once the response is gone
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      if (ar_hs) begin
        arready <= 1'b0;
      end else if (!rvalid || rready) begin
        arready <= 1'b1;
      end
      if (ar_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Read word captured at acceptance, held through back-pressure
  always_ff @(posedge s_axi_aclk) begin
    if (ar_hs) begin
      rdata <= rd_data;
    end
  end

  assign rresp = RESP_OKAY;

  // Data must not change while the host stalls
  a_rdata_stable: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata)
  );

  // Only one read in flight
  a_no_ar_while_rvalid: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    rvalid |-> !ar_hs
  );

endmodule

// ==== hdl/axi_write_path.sv ====
// AXI4-Lite write side of the dummy peripheral
// Joins AW and W beats in any order, issues one register write
// and holds the OKAY response until the host takes it

`timescale 1ns/10ps

`include "axi_periph_config.svh"

module axi_write_path (
  input  logic                      s_axi_aclk,
  input  logic                      s_axi_aresetn,
  input  axi_periph_pkg::axi_addr_t awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  axi_periph_pkg::axi_data_t wdata,
  input  axi_periph_pkg::axi_strb_t wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output axi_periph_pkg::axi_resp_t bresp,
  output logic                      bvalid,
  input  logic                      bready,
  output logic                      wr_en,
  output axi_periph_pkg::reg_idx_t  wr_idx,
  output axi_periph_pkg::axi_data_t wr_data,
  output axi_periph_pkg::axi_strb_t wr_strb
);

  import axi_periph_pkg::*;

  // Holder state and bypass views
  logic      aw_full;
  logic      w_full;
  axi_addr_t aw_beat;
  wr_beat_t  w_in;
  wr_beat_t  w_beat;

  // A beat counts as present if held or handshaking right now
  logic aw_present;
  logic w_present;
  // B handshake frees both holders
  logic b_done;

  assign w_in.data = wdata;
  assign w_in.strb = wstrb;

  axi_chan_hold #(.payload_t(axi_addr_t)) i_aw_hold (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .valid         (awvalid),
    .payload       (awaddr),
    .release_beat  (b_done),
    .ready         (awready),
    .full          (aw_full),
    .beat          (aw_beat)
  );

  axi_chan_hold #(.payload_t(wr_beat_t)) i_w_hold (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .valid         (wvalid),
    .payload       (w_in),
    .release_beat  (b_done),
    .ready         (wready),
    .full          (w_full),
    .beat          (w_beat)
  );

  assign aw_present = aw_full || (awvalid && awready);
  assign w_present  = w_full || (wvalid && wready);
  assign b_done     = bvalid && bready;

  // Exactly one write per transaction, blocked while a response waits
  assign wr_en   = aw_present && w_present && !bvalid;
  assign wr_idx  = aw_beat[`REG_ADDR_LSB +: `REG_IDX_W];
  assign wr_data = w_beat.data;
  assign wr_strb = w_beat.strb;

  // Response follows the register update by one cycle
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      bvalid <= 1'b0;
    end else if (wr_en) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  assign bresp = RESP_OKAY;

  // Response may not be withdrawn before the host accepts it
  a_bvalid_hold: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    bvalid && !bready |=> bvalid
  );

endmodule

// ==== hdl/axi_chan_hold.sv ====
// One-beat holding register for an AXI request channel
// Generates ready, flags a held beat and gives a bypass view of the payload

`timescale 1ns/10ps

module axi_chan_hold #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     s_axi_aclk,
  input  logic     s_axi_aresetn,
  input  logic     valid,
  input  payload_t payload,
  input  logic     release_beat,
  output logic     ready,
  output logic     full,
  output payload_t beat
);

  // Copy of the accepted beat
  payload_t held;

  // Handshake on this channel
  logic capture;

  assign capture = valid && ready;

  // Ready comes up one cycle after reset and after each release
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      ready <= 1'b0;
      full  <= 1'b0;
    end else if (release_beat) begin
      full  <= 1'b0;
      ready <= 1'b1;
    end else if (capture) begin
      // Stop accepting until the transaction completes
      full  <= 1'b1;
      ready <= 1'b0;
    end else if (!full) begin
      ready <= 1'b1;
    end
  end

  // Payload copy
  always_ff @(posedge s_axi_aclk) begin
    if (capture) begin
      held <= payload;
    end
  end

  // Live input while empty so the consumer can act in the arrival cycle
  assign beat = full ? held : payload;

  // The consumer only ever releases a beat that is actually held
  a_release_when_full: assert property (
    @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    release_beat |-> full
  );

endmodule

// ==== hdl/axi_periph_pkg.sv ====
// Shared types for the AXI4-Lite dummy peripheral
// Bus words, register index and strobe vector, response code, write beat

`include "axi_periph_config.svh"

package axi_periph_pkg;

  // Raw bus fields
  typedef logic [`AXI_ADDR_W-1:0]   axi_addr_t;
  typedef logic [`AXI_DATA_W-1:0]   axi_data_t;
  typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;

  // Register selection and per-register update pulses
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`REG_COUNT-1:0] reg_strobe_t;

  // Response code, this target only ever answers OKAY
  typedef enum logic [1:0] {
    RESP_OKAY = 2'b00
  } axi_resp_t;

  // Write data channel beat, data word plus byte strobes
  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } wr_beat_t;

endpackage

// ==== hdl/axi_periph_config.svh ====
// Build-time sizes for the AXI4-Lite dummy peripheral
// Bus widths, register index layout and reset pattern base

`ifndef AXI_PERIPH_CONFIG_SVH
`define AXI_PERIPH_CONFIG_SVH

// Byte address width of the slave port
`define AXI_ADDR_W 8
// Data word width
`define AXI_DATA_W 32

// Register index sits in address bits 7:2
`define REG_IDX_W 6
`define REG_ADDR_LSB 2
`define REG_COUNT (1 << `REG_IDX_W)

// Register n resets to this base plus its byte address
`define REG_INIT_BASE 32'h0000_0100

`endif
